//--- rtl/embed_mode_decode.sv
`include "stego_macros.svh"

module embed_mode_decode (
   input  logic [`STEGO_SW_W-1:0] switches,
   output stego_pkg::lsb_plan_t   plan
);

   always_comb begin
      plan = '0;
      case (switches)
         // 6 bits, 4 pixels per word
         `STEGO_SW_W'd1: begin
            plan.r_bits = 2'd2;
            plan.g_bits = 2'd2;
            plan.b_bits = 2'd2;
         end
         // 3 bits, 8 pixels per word
         `STEGO_SW_W'd2: begin
            plan.r_bits = 2'd1;
            plan.g_bits = 2'd1;
            plan.b_bits = 2'd1;
         end
         // red only, 24 pixels per word
         `STEGO_SW_W'd4: begin
            plan.r_bits = 2'd1;
            plan.g_bits = 2'd0;
            plan.b_bits = 2'd0;
         end
         // 4 bits, 6 pixels per word
         `STEGO_SW_W'd8: begin
            plan.r_bits = 2'd2;
            plan.g_bits = 2'd1;
            plan.b_bits = 2'd1;
         end
         // red and blue, 12 pixels per word
         `STEGO_SW_W'd16: begin
            plan.r_bits = 2'd1;
            plan.g_bits = 2'd0;
            plan.b_bits = 2'd1;
         end
         default: begin
            // every other value is passthrough
            plan = '0;
         end
      endcase
   end

endmodule

//--- rtl/lsb_embed.sv
`include "stego_macros.svh"

module lsb_embed (
   input  logic                  in_valid,
   output logic                  in_ready,
   input  stego_pkg::pixel_t     pix,
   input  logic                  chunk_valid,
   output logic                  chunk_ready,
   input  stego_pkg::msg_chunk_t chunk,
   output logic                  out_valid,
   input  logic                  out_ready,
   output stego_pkg::pixel_t     out_pix
);

   // replace the n low bits of ch with the low bits of src
   function automatic logic [`STEGO_CH_W-1:0] insert_lsb(
      input logic [`STEGO_CH_W-1:0]   ch,
      input logic [`STEGO_MAX_LSB-1:0] src,
      input logic [1:0]               n
   );
      logic [`STEGO_CH_W-1:0] keep_mask;
      logic [`STEGO_CH_W-1:0] src_ext;
      keep_mask = {`STEGO_CH_W{1'b1}} << n;
      src_ext   = {{(`STEGO_CH_W - `STEGO_MAX_LSB){1'b0}}, src};
      return (ch & keep_mask) | (src_ext & ~keep_mask);
   endfunction

   logic [`STEGO_CHUNK_W-1:0] g_src;
   logic [`STEGO_CHUNK_W-1:0] r_src;

   // join, each side consumed only on an output transfer
   assign out_valid   = in_valid && chunk_valid;
   assign in_ready    = out_ready && chunk_valid;
   assign chunk_ready = out_ready && in_valid;

   // blue first, then green, red gets the highest bits
   assign g_src = chunk.bits >> chunk.plan.b_bits;
   assign r_src = g_src >> chunk.plan.g_bits;

   assign out_pix.b = insert_lsb(pix.b, chunk.bits[`STEGO_MAX_LSB-1:0], chunk.plan.b_bits);
   assign out_pix.g = insert_lsb(pix.g, g_src[`STEGO_MAX_LSB-1:0], chunk.plan.g_bits);
   assign out_pix.r = insert_lsb(pix.r, r_src[`STEGO_MAX_LSB-1:0], chunk.plan.r_bits);

endmodule

//--- rtl/message_slicer.sv
`include "stego_macros.svh"

module message_slicer (
   input  logic                     clk,
   input  logic                     rst,
   input  stego_pkg::lsb_plan_t     plan,
   input  logic                     msg_valid,
   output logic                     msg_ready,
   input  logic [`STEGO_MSG_W-1:0]  msg,
   output logic                     chunk_valid,
   input  logic                     chunk_ready,
   output stego_pkg::msg_chunk_t    chunk
);

   localparam int CNT_W = $clog2(`STEGO_MSG_W + 1);

   logic [`STEGO_MSG_W-1:0]   word_q;
   logic [CNT_W-1:0]          remain_q;
   stego_pkg::lsb_plan_t      plan_q;
   logic [CNT_W-1:0]          step;
   logic [`STEGO_CHUNK_W-1:0] mask;
   logic                      empty;
   logic                      live_zero;
   logic                      take;
   logic                      last_take;
   logic                      load;

   // bits used per pixel under the latched plan
   assign step = CNT_W'(plan_q.r_bits) + CNT_W'(plan_q.g_bits) + CNT_W'(plan_q.b_bits);
   assign mask = ~({`STEGO_CHUNK_W{1'b1}} << step);

   assign empty     = (remain_q == '0);
   assign live_zero = (plan == '0);

   // empty under passthrough still feeds zero-bit chunks
   assign chunk_valid = !empty || live_zero;

   always_comb begin
      chunk = '0;
      if (!empty) begin
         chunk.plan = plan_q;
         chunk.bits = word_q[`STEGO_CHUNK_W-1:0] & mask;
      end
   end

   assign take      = chunk_valid && chunk_ready && !empty;
   assign last_take = take && (remain_q == step);

   // next word may come in on the same edge the last chunk leaves
   assign msg_ready = !live_zero && (empty || last_take);
   assign load      = msg_valid && msg_ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         remain_q <= '0;
         plan_q   <= '0;
      end else if (load) begin
         remain_q <= CNT_W'(`STEGO_MSG_W);
         plan_q   <= plan;
      end else if (take) begin
         remain_q <= remain_q - step;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         word_q <= msg;
      end else if (take) begin
         word_q <= word_q >> step;
      end
   end

endmodule

//--- rtl/pipe_stage.sv
module pipe_stage #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   logic     valid_q;
   payload_t data_q;

   // full throughput, refill in the cycle the held item leaves
   assign in_ready  = !valid_q || out_ready;
   assign out_valid = valid_q;
   assign out_data  = data_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else if (in_valid && in_ready) begin
         valid_q <= 1'b1;
      end else if (out_ready) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         data_q <= in_data;
      end
   end

endmodule

//--- rtl/stego_encoder.sv
`include "stego_macros.svh"

module stego_encoder (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`STEGO_SW_W-1:0]  switches,
   input  logic                    pix_valid,
   output logic                    pix_ready,
   input  stego_pkg::pixel_t       pix,
   input  logic                    msg_valid,
   output logic                    msg_ready,
   input  logic [`STEGO_MSG_W-1:0] msg,
   output logic                    stego_valid,
   input  logic                    stego_ready,
   output stego_pkg::pixel_t       stego
);

   // registered pixel into the embedder
   logic                  reg_valid;
   logic                  reg_ready;
   stego_pkg::pixel_t     reg_pix;

   stego_pkg::lsb_plan_t  plan;

   logic                  chunk_valid;
   logic                  chunk_ready;
   stego_pkg::msg_chunk_t chunk;

   // embedded pixel into the output register
   logic                  emb_valid;
   logic                  emb_ready;
   stego_pkg::pixel_t     emb_pix;

   pipe_stage #(
      .payload_t (stego_pkg::pixel_t)
   ) in_stage (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (pix_valid),
      .in_ready  (pix_ready),
      .in_data   (pix),
      .out_valid (reg_valid),
      .out_ready (reg_ready),
      .out_data  (reg_pix)
   );

   embed_mode_decode u_decode (
      .switches (switches),
      .plan     (plan)
   );

   message_slicer u_slicer (
      .clk         (clk),
      .rst         (rst),
      .plan        (plan),
      .msg_valid   (msg_valid),
      .msg_ready   (msg_ready),
      .msg         (msg),
      .chunk_valid (chunk_valid),
      .chunk_ready (chunk_ready),
      .chunk       (chunk)
   );

   lsb_embed u_embed (
      .in_valid    (reg_valid),
      .in_ready    (reg_ready),
      .pix         (reg_pix),
      .chunk_valid (chunk_valid),
      .chunk_ready (chunk_ready),
      .chunk       (chunk),
      .out_valid   (emb_valid),
      .out_ready   (emb_ready),
      .out_pix     (emb_pix)
   );

   pipe_stage #(
      .payload_t (stego_pkg::pixel_t)
   ) out_stage (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (emb_valid),
      .in_ready  (emb_ready),
      .in_data   (emb_pix),
      .out_valid (stego_valid),
      .out_ready (stego_ready),
      .out_data  (stego)
   );

endmodule

//--- rtl/stego_macros.svh
`ifndef STEGO_MACROS_SVH
`define STEGO_MACROS_SVH

// one colour channel
`define STEGO_CH_W 8

// message word, a multiple of every per-pixel bit count
`define STEGO_MSG_W 24

// one-hot mode switches
`define STEGO_SW_W 6

// most LSBs replaced in one channel
`define STEGO_MAX_LSB 2
`define STEGO_CHUNK_W (3 * `STEGO_MAX_LSB)

`endif

//--- rtl/stego_pkg.sv
`include "stego_macros.svh"

package stego_pkg;

   // rgb pixel, red in the top byte
   typedef struct packed {
      logic [`STEGO_CH_W-1:0] r;
      logic [`STEGO_CH_W-1:0] g;
      logic [`STEGO_CH_W-1:0] b;
   } pixel_t;

   // LSBs replaced per channel, all zero is passthrough
   typedef struct packed {
      logic [1:0] r_bits;
      logic [1:0] g_bits;
      logic [1:0] b_bits;
   } lsb_plan_t;

   // message bits for one pixel plus the plan they were cut with
   // bits is aligned to bit 0, blue takes the lowest bits
   typedef struct packed {
      lsb_plan_t                plan;
      logic [`STEGO_CHUNK_W-1:0] bits;
   } msg_chunk_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run the stego encoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
   --top-module stego_tb \
   -f sources.f \
   -o stego_sim

# exit status of the simulation is the test result
./obj_dir/stego_sim

//--- sources.f
+incdir+rtl
+incdir+verif
rtl/stego_pkg.sv
rtl/embed_mode_decode.sv
rtl/message_slicer.sv
rtl/lsb_embed.sv
rtl/pipe_stage.sv
rtl/stego_encoder.sv
verif/stego_tb.sv

//--- verif/stego_tb_model.svh
`ifndef STEGO_TB_MODEL_SVH
`define STEGO_TB_MODEL_SVH

// expected stego pixels and their source pixels, oldest first
stego_pkg::pixel_t       exp_q[$];
stego_pkg::pixel_t       src_q[$];

// message words in send order, and the next unused message bit
logic [`STEGO_MSG_W-1:0] sent_words[$];
int                      bit_pos = 0;

function automatic logic [31:0] lcg_next(inout logic [31:0] state);
   state = state * 32'd1103515245 + 32'd12345;
   return state;
endfunction

// LSBs per channel, ch 0 is red, 1 green, 2 blue
function automatic int lsb_count(input logic [`STEGO_SW_W-1:0] sw, input int ch);
   case (sw)
      `STEGO_SW_W'd1:  return 2;
      `STEGO_SW_W'd2:  return 1;
      `STEGO_SW_W'd4:  return (ch == 0) ? 1 : 0;
      `STEGO_SW_W'd8:  return (ch == 0) ? 2 : 1;
      `STEGO_SW_W'd16: return (ch == 1) ? 0 : 1;
      default:         return 0;
   endcase
endfunction

function automatic logic [`STEGO_CH_W-1:0] set_bit(
   input logic [`STEGO_CH_W-1:0] value,
   input int                     pos,
   input logic                   b
);
   logic [`STEGO_CH_W-1:0] one;
   one = `STEGO_CH_W'(1) << pos;
   if (b) begin
      return value | one;
   end else begin
      return value & ~one;
   end
endfunction

// message stream is consumed lowest bit of each word first
function automatic logic next_bit();
   logic [`STEGO_MSG_W-1:0] word;
   word    = sent_words[bit_pos / `STEGO_MSG_W];
   word    = word >> (bit_pos % `STEGO_MSG_W);
   bit_pos = bit_pos + 1;
   return word[0];
endfunction

function automatic stego_pkg::pixel_t embed_ref(
   input stego_pkg::pixel_t       src,
   input logic [`STEGO_SW_W-1:0] sw
);
   stego_pkg::pixel_t res;
   int                j;
   res = src;
   // blue takes the first bits, red the last
   for (j = 0; j < lsb_count(sw, 2); j++) begin
      res.b = set_bit(res.b, j, next_bit());
   end
   for (j = 0; j < lsb_count(sw, 1); j++) begin
      res.g = set_bit(res.g, j, next_bit());
   end
   for (j = 0; j < lsb_count(sw, 0); j++) begin
      res.r = set_bit(res.r, j, next_bit());
   end
   return res;
endfunction

`endif

//--- verif/stego_tb.sv
`include "stego_macros.svh"

module stego_tb;

   // 8+16+48+12+24 embedding, 20 passthrough, 12 under back-pressure
   localparam int PIX_TOTAL   = 140;
   localparam int CYCLE_LIMIT = PIX_TOTAL * 8 + 200;

   logic                    clk = 1'b0;
   logic                    rst;
   logic [`STEGO_SW_W-1:0]  switches;
   logic                    pix_valid;
   logic                    pix_ready;
   stego_pkg::pixel_t       pix;
   logic                    msg_valid;
   logic                    msg_ready;
   logic [`STEGO_MSG_W-1:0] msg;
   logic                    stego_valid;
   logic                    stego_ready = 1'b1;
   stego_pkg::pixel_t       stego;

   logic                    passthru;
   logic                    drop_en;
   logic [31:0]             data_seed;
   logic [31:0]             ready_seed = 32'd26170;
   int                      cycles = 0;
   int                      run_pix = 0;
   int                      run_words = 0;
   int                      word_pix = 0;
   logic [`STEGO_MSG_W-1:0] word_q[$];

   `include "stego_tb_model.svh"

   stego_encoder UUT (
      .clk         (clk),
      .rst         (rst),
      .switches    (switches),
      .pix_valid   (pix_valid),
      .pix_ready   (pix_ready),
      .pix         (pix),
      .msg_valid   (msg_valid),
      .msg_ready   (msg_ready),
      .msg         (msg),
      .stego_valid (stego_valid),
      .stego_ready (stego_ready),
      .stego       (stego)
   );

   always #4 clk = ~clk;

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         fail_now($sformatf("simulation timed out after %0d cycles", cycles));
      end
   end

   // random stalls on the output side
   always @(posedge clk) begin : ready_drive
      logic [31:0] rnd;
      #1;
      if (drop_en) begin
         rnd         = lcg_next(ready_seed);
         stego_ready = (rnd[31:30] != 2'b00);
      end else begin
         stego_ready = 1'b1;
      end
   end

   // output check, then message word, then prediction for a newly accepted pixel
   always @(posedge clk) begin : monitor
      stego_pkg::pixel_t want;
      stego_pkg::pixel_t src;
      if (!rst && stego_valid && stego_ready) begin
         assert (exp_q.size() != 0)
            else fail_now("stego transfer while no pixel was outstanding");
         want = exp_q.pop_front();
         src  = src_q.pop_front();
         assert ({stego.r[7:2], stego.g[7:2], stego.b[7:2]} ==
                 {src.r[7:2], src.g[7:2], src.b[7:2]})
            else fail_now($sformatf("[ERROR] stego upper bits expected 0x%06h actual 0x%06h",
                                    src, stego));
         assert (stego == want)
            else fail_now($sformatf("[ERROR] stego expected 0x%06h actual 0x%06h",
                                    want, stego));
      end
      // a new word only comes in once the previous one has covered its pixels
      if (!rst && msg_valid && msg_ready) begin
         assert (run_pix == run_words * word_pix)
            else fail_now($sformatf("[ERROR] pixels before msg word expected 0x%0h actual 0x%0h",
                                    run_words * word_pix, run_pix));
         run_words = run_words + 1;
      end
      if (!rst && pix_valid && pix_ready) begin
         exp_q.push_back(embed_ref(pix, switches));
         src_q.push_back(pix);
         run_pix = run_pix + 1;
      end
   end

   stall_valid: assert property (@(posedge clk) disable iff (rst)
      stego_valid && !stego_ready |=> stego_valid)
      else fail_now("stego_valid fell while stego_ready was low");

   stall_data: assert property (@(posedge clk) disable iff (rst)
      stego_valid && !stego_ready |=> $stable(stego))
      else fail_now("stego changed while stego_ready was low");

   quiet_msg: assert property (@(posedge clk) disable iff (rst)
      passthru |-> !msg_ready)
      else fail_now("msg_ready went high in passthrough mode");

   task automatic send_words();
      while (word_q.size() != 0) begin
         msg       = word_q.pop_front();
         msg_valid = 1'b1;
         do begin
            @(posedge clk);
         end while (!msg_ready);
         #1;
      end
      msg_valid = 1'b0;
   endtask

   task automatic send_pixels(input int n);
      logic [31:0] rnd;
      int          i;
      for (i = 0; i < n; i++) begin
         rnd       = lcg_next(data_seed);
         pix       = rnd[31:8];
         pix_valid = 1'b1;
         do begin
            @(posedge clk);
         end while (!pix_ready);
         #1;
      end
      pix_valid = 1'b0;
   endtask

   // switches only change once everything has drained
   task automatic run_mode(input logic [`STEGO_SW_W-1:0] sw, input int n_words,
                           input int n_pix, input logic drops);
      logic [31:0] rnd;
      int          bits;
      int          i;
      @(posedge clk);
      drop_en = drops;
      #1;
      switches  = sw;
      bits      = lsb_count(sw, 0) + lsb_count(sw, 1) + lsb_count(sw, 2);
      passthru  = (bits == 0);
      word_pix  = passthru ? 0 : `STEGO_MSG_W / bits;
      run_pix   = 0;
      run_words = 0;
      for (i = 0; i < n_words; i++) begin
         rnd = lcg_next(data_seed);
         word_q.push_back(rnd[31:8]);
         sent_words.push_back(rnd[31:8]);
      end
      fork
         send_words();
         send_pixels(n_pix);
      join
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      @(posedge clk);
      // slicer must be empty exactly when the last pixel of the last word is out
      assert (msg_ready == !passthru)
         else fail_now($sformatf("[ERROR] msg_ready expected 0x%0h actual 0x%0h",
                                 !passthru, msg_ready));
      assert (stego_valid == 1'b0)
         else fail_now($sformatf("[ERROR] stego_valid expected 0x0 actual 0x%0h",
                                 stego_valid));
   endtask

   initial begin
      rst       = 1'b1;
      switches  = '0;
      pix_valid = 1'b0;
      pix       = '0;
      msg_valid = 1'b0;
      msg       = '0;
      passthru  = 1'b1;
      drop_en   = 1'b0;
      data_seed = 32'd26170;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      @(posedge clk);
      assert (stego_valid == 1'b0)
         else fail_now($sformatf("[ERROR] stego_valid expected 0x0 actual 0x%0h",
                                 stego_valid));
      assert (msg_ready == 1'b0)
         else fail_now($sformatf("[ERROR] msg_ready expected 0x0 actual 0x%0h", msg_ready));
      assert (pix_ready == 1'b1)
         else fail_now($sformatf("[ERROR] pix_ready expected 0x1 actual 0x%0h", pix_ready));

      run_mode(`STEGO_SW_W'd1, 2, 8, 1'b0);
      run_mode(`STEGO_SW_W'd2, 2, 16, 1'b0);
      run_mode(`STEGO_SW_W'd4, 2, 48, 1'b0);
      run_mode(`STEGO_SW_W'd8, 2, 12, 1'b0);
      run_mode(`STEGO_SW_W'd16, 2, 24, 1'b0);
      // passthrough for zero and for switch value 32
      run_mode(`STEGO_SW_W'd0, 0, 10, 1'b0);
      run_mode(`STEGO_SW_W'd32, 0, 10, 1'b0);
      run_mode(`STEGO_SW_W'd8, 2, 12, 1'b1);

      $display("All tests passed");
      $finish;
   end

endmodule
